//--- Bender.yml
package:
  name: ooo_core

sources:
  - files:
      - common/ooo_pkg.sv
      - hdl/ooo_fetch_stage.sv
      - decode/ooo_decode_stage.sv
      - execute/ooo_execute_stage.sv
      - commit/completion_buffer.sv
      - hdl/rv32i_reg_file.sv
      - hdl/ooo_core.sv
  - target: test
    files:
      - testbench/ooo_core_tb.sv

//--- commit/completion_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module completion_buffer #(
   parameter int CB_DEPTH = 8
) (
   input  wire                     CLK,
   input  wire                     rst_n,
   input  wire                     alloc,
   input  wire ooo_pkg::reg_idx_t  alloc_rd,
   input  wire                     alloc_wen,
   input  wire ooo_pkg::data_t     alloc_pc,
   output ooo_pkg::cb_tag_t        alloc_tag,
   output logic                    cb_full,
   input  wire ooo_pkg::complete_t alu_done,
   input  wire ooo_pkg::complete_t mul_done,
   output logic [31:0]             busy_regs,
   output ooo_pkg::commit_t        commit
);

   import ooo_pkg::*;

   localparam int ptr_w = $clog2(CB_DEPTH);

   logic [ptr_w-1:0]    head;
   logic [ptr_w-1:0]    tail;
   logic [ptr_w:0]      count;
   logic [CB_DEPTH-1:0] ent_live;
   logic [CB_DEPTH-1:0] ent_done;
   logic [CB_DEPTH-1:0] ent_wen;
   reg_idx_t            ent_rd   [CB_DEPTH];
   data_t               ent_pc   [CB_DEPTH];
   data_t               ent_data [CB_DEPTH];
   logic [ptr_w-1:0]    alu_idx;
   logic [ptr_w-1:0]    mul_idx;
   logic                retire;

   assign alu_idx   = alu_done.tag[ptr_w-1:0];
   assign mul_idx   = mul_done.tag[ptr_w-1:0];
   assign alloc_tag = cb_tag_t'(tail);
   assign cb_full   = (count == (ptr_w+1)'(CB_DEPTH));
   assign retire    = ent_live[head] && ent_done[head];  // Oldest one finished.

   // ##############################
   // Pointers, flags and commit
   // ##############################

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         head         <= '0;
         tail         <= '0;
         count        <= '0;
         ent_live     <= '0;
         ent_done     <= '0;
         commit.valid <= 1'b0;
      end else begin
         if (alloc) begin
            ent_live[tail] <= 1'b1;
            ent_done[tail] <= 1'b0;
            tail           <= tail + 1'b1;
         end
         // Both units may finish in one cycle, on different tags.
         if (alu_done.valid) begin
            ent_done[alu_idx] <= 1'b1;
         end
         if (mul_done.valid) begin
            ent_done[mul_idx] <= 1'b1;
         end
         if (retire) begin
            ent_live[head] <= 1'b0;
            head           <= head + 1'b1;
            commit.wen     <= ent_wen[head];
            commit.rd      <= ent_rd[head];
            commit.data    <= ent_data[head];
            commit.pc      <= ent_pc[head];
         end
         commit.valid <= retire;
         count        <= count + (ptr_w+1)'(alloc) - (ptr_w+1)'(retire);
      end
   end

   // ##############################
   // Entry payload
   // ##############################

   always_ff @(posedge CLK) begin
      if (alloc) begin
         ent_rd[tail]  <= alloc_rd;
         ent_wen[tail] <= alloc_wen;
         ent_pc[tail]  <= alloc_pc;
      end
      if (alu_done.valid) begin
         ent_data[alu_idx] <= alu_done.data;
      end
      if (mul_done.valid) begin
         ent_data[mul_idx] <= mul_done.data;
      end
   end

   // Registers with a write still in flight.
   always_comb begin
      busy_regs = '0;
      for (int i = 0; i < CB_DEPTH; i++) begin
         if (ent_live[i] && ent_wen[i]) begin
            busy_regs[ent_rd[i]] = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- common/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

   // ##############################
   // Widths and scalar types
   // ##############################

   localparam int xlen = 32;
   localparam int cb_tag_w = 4;  // Up to 16 buffer entries.

   typedef logic [xlen-1:0] data_t;
   typedef logic [4:0] reg_idx_t;
   typedef logic [cb_tag_w-1:0] cb_tag_t;

   // ADDI reuses op_add, op_nop writes nothing.
   typedef enum logic [2:0] {
      op_add,
      op_sub,
      op_and,
      op_or,
      op_xor,
      op_mul,
      op_nop
   } exec_op_e;

   // ##############################
   // Stage payloads
   // ##############################

   typedef struct packed {
      logic  valid;
      data_t instr;
      data_t pc;
   } fetch_t;

   typedef struct packed {
      logic     valid;
      cb_tag_t  tag;
      exec_op_e op;
      data_t    a;
      data_t    b;  // Register or sign-extended immediate.
   } issue_t;

   typedef struct packed {
      logic    valid;
      cb_tag_t tag;
      data_t   data;
   } complete_t;

   typedef struct packed {
      logic     valid;
      logic     wen;
      reg_idx_t rd;
      data_t    data;
      data_t    pc;
   } commit_t;

endpackage

`default_nettype wire

//--- decode/ooo_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_decode_stage #(
   parameter int CB_DEPTH = 8
) (
   input  wire                   CLK,
   input  wire                   rst_n,
   input  wire ooo_pkg::fetch_t  fetch,
   output logic                  hold,
   output ooo_pkg::reg_idx_t     rs1,
   output ooo_pkg::reg_idx_t     rs2,
   input  wire ooo_pkg::data_t   rs1_data,
   input  wire ooo_pkg::data_t   rs2_data,
   input  wire [31:0]            busy_regs,
   input  wire                   cb_full,
   input  wire ooo_pkg::cb_tag_t alloc_tag,
   output logic                  alloc,
   output ooo_pkg::reg_idx_t     alloc_rd,
   output logic                  alloc_wen,
   output ooo_pkg::data_t        alloc_pc,
   output ooo_pkg::issue_t       issue
);

   import ooo_pkg::*;

   localparam logic [6:0] opc_op     = 7'b0110011;
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam int tag_mask = CB_DEPTH - 1;

   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   reg_idx_t    rd;
   data_t       imm_i;
   exec_op_e    op;
   logic        use_rs1;
   logic        use_rs2;
   logic [31:0] busy_q;
   logic [31:0] busy_any;
   logic        src_busy;

   assign opcode = fetch.instr[6:0];
   assign rd     = fetch.instr[11:7];
   assign funct3 = fetch.instr[14:12];
   assign rs1    = fetch.instr[19:15];
   assign rs2    = fetch.instr[24:20];
   assign funct7 = fetch.instr[31:25];
   assign imm_i  = {{20{fetch.instr[31]}}, fetch.instr[31:20]};

   always_comb begin
      op      = op_nop;
      use_rs1 = 1'b0;
      use_rs2 = 1'b0;
      if (opcode == opc_op) begin
         case ({funct7, funct3})
            {7'b0000000, 3'b000}: op = op_add;
            {7'b0100000, 3'b000}: op = op_sub;
            {7'b0000000, 3'b111}: op = op_and;
            {7'b0000000, 3'b110}: op = op_or;
            {7'b0000000, 3'b100}: op = op_xor;
            {7'b0000001, 3'b000}: op = op_mul;
            default:              op = op_nop;
         endcase
         use_rs1 = (op != op_nop);
         use_rs2 = (op != op_nop);
      end else if (opcode == opc_op_imm && funct3 == 3'b000) begin
         op      = op_add;  // ADDI.
         use_rs1 = 1'b1;
      end
   end

   // ##############################
   // Hazard check
   // ##############################

   // A busy bit that just dropped means the commit write lands next edge.
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         busy_q <= '0;
      end else begin
         busy_q <= busy_regs;
      end
   end

   assign busy_any = busy_regs | busy_q;
   assign src_busy = (use_rs1 && busy_any[rs1]) || (use_rs2 && busy_any[rs2]);
   assign hold     = fetch.valid && (cb_full || src_busy);

   // ##############################
   // Allocate and issue
   // ##############################

   assign alloc     = fetch.valid && !hold;
   assign alloc_rd  = rd;
   assign alloc_wen = (op != op_nop) && (rd != '0);  // x0 and unknown words.
   assign alloc_pc  = fetch.pc;

   always_comb begin
      issue.valid = alloc;
      issue.tag   = alloc_tag & cb_tag_t'(tag_mask);
      issue.op    = op;
      issue.a     = rs1_data;
      issue.b     = use_rs2 ? rs2_data : imm_i;
   end

endmodule

`default_nettype wire

//--- execute/ooo_execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_execute_stage #(
   parameter int MUL_STAGES = 3
) (
   input  wire                   CLK,
   input  wire                   rst_n,
   input  wire ooo_pkg::issue_t  issue,
   output ooo_pkg::complete_t    alu_done,
   output ooo_pkg::complete_t    mul_done
);

   import ooo_pkg::*;

   logic      is_mul;
   data_t     alu_result;
   data_t     mul_product;
   complete_t mul_pipe [MUL_STAGES];

   assign is_mul = (issue.op == op_mul);

   // ##############################
   // Single-cycle ALU
   // ##############################

   always_comb begin
      case (issue.op)
         op_add:  alu_result = issue.a + issue.b;
         op_sub:  alu_result = issue.a - issue.b;
         op_and:  alu_result = issue.a & issue.b;
         op_or:   alu_result = issue.a | issue.b;
         op_xor:  alu_result = issue.a ^ issue.b;
         default: alu_result = '0;  // NOP retires with zero.
      endcase
   end

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         alu_done.valid <= 1'b0;
      end else begin
         alu_done.valid <= issue.valid && !is_mul;
         alu_done.tag   <= issue.tag;
         alu_done.data  <= alu_result;
      end
   end

   // ##############################
   // Pipelined multiplier
   // ##############################

   assign mul_product = issue.a * issue.b;  // Low word of the product.

   // No stall inside the chain, a new MUL may enter every cycle.
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         for (int i = 0; i < MUL_STAGES; i++) begin
            mul_pipe[i].valid <= 1'b0;
         end
      end else begin
         mul_pipe[0].valid <= issue.valid && is_mul;
         mul_pipe[0].tag   <= issue.tag;
         mul_pipe[0].data  <= mul_product;
         for (int i = 1; i < MUL_STAGES; i++) begin
            mul_pipe[i] <= mul_pipe[i-1];
         end
      end
   end

   assign mul_done = mul_pipe[MUL_STAGES-1];

endmodule

`default_nettype wire

//--- hdl/ooo_core.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core #(
   parameter int CB_DEPTH   = 8,
   parameter int MUL_STAGES = 3
) (
   input  wire                  CLK,
   input  wire                  rst_n,
   input  wire                  instr_valid,
   input  wire ooo_pkg::data_t  instr_data,
   output logic                 instr_stall,
   output ooo_pkg::commit_t     commit
);

   import ooo_pkg::*;

   fetch_t      fetch;
   logic        hold;
   reg_idx_t    rs1;
   reg_idx_t    rs2;
   data_t       rs1_data;
   data_t       rs2_data;
   logic [31:0] busy_regs;
   logic        cb_full;
   cb_tag_t     alloc_tag;
   logic        alloc;
   reg_idx_t    alloc_rd;
   logic        alloc_wen;
   data_t       alloc_pc;
   issue_t      issue;
   complete_t   alu_done;
   complete_t   mul_done;
   logic        rf_wen;

   ooo_fetch_stage fetch_stage (
       .CLK(CLK)
      ,.rst_n(rst_n)
      ,.instr_valid(instr_valid)
      ,.instr_data(instr_data)
      ,.hold(hold)
      ,.fetch(fetch)
      ,.instr_stall(instr_stall)
   );

   ooo_decode_stage #(.CB_DEPTH(CB_DEPTH)) decode_stage (
       .CLK(CLK)
      ,.rst_n(rst_n)
      ,.fetch(fetch)
      ,.hold(hold)
      ,.rs1(rs1)
      ,.rs2(rs2)
      ,.rs1_data(rs1_data)
      ,.rs2_data(rs2_data)
      ,.busy_regs(busy_regs)
      ,.cb_full(cb_full)
      ,.alloc_tag(alloc_tag)
      ,.alloc(alloc)
      ,.alloc_rd(alloc_rd)
      ,.alloc_wen(alloc_wen)
      ,.alloc_pc(alloc_pc)
      ,.issue(issue)
   );

   ooo_execute_stage #(.MUL_STAGES(MUL_STAGES)) execute_stage (
       .CLK(CLK)
      ,.rst_n(rst_n)
      ,.issue(issue)
      ,.alu_done(alu_done)
      ,.mul_done(mul_done)
   );

   completion_buffer #(.CB_DEPTH(CB_DEPTH)) cb (
       .CLK(CLK)
      ,.rst_n(rst_n)
      ,.alloc(alloc)
      ,.alloc_rd(alloc_rd)
      ,.alloc_wen(alloc_wen)
      ,.alloc_pc(alloc_pc)
      ,.alloc_tag(alloc_tag)
      ,.cb_full(cb_full)
      ,.alu_done(alu_done)
      ,.mul_done(mul_done)
      ,.busy_regs(busy_regs)
      ,.commit(commit)
   );

   // Retired results go straight into the register file.
   assign rf_wen = commit.valid && commit.wen;

   rv32i_reg_file rg_file (
       .CLK(CLK)
      ,.rst_n(rst_n)
      ,.rs1(rs1)
      ,.rs2(rs2)
      ,.rs1_data(rs1_data)
      ,.rs2_data(rs2_data)
      ,.wen(rf_wen)
      ,.rd(commit.rd)
      ,.wdata(commit.data)
   );

endmodule

`default_nettype wire

//--- hdl/ooo_fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_fetch_stage (
   input  wire                  CLK,
   input  wire                  rst_n,
   input  wire                  instr_valid,
   input  wire ooo_pkg::data_t  instr_data,
   input  wire                  hold,
   output ooo_pkg::fetch_t      fetch,
   output logic                 instr_stall
);

   import ooo_pkg::*;

   data_t pc_q;  // Pc for the next accepted word.

   // Hold only rises with a valid word sitting in the register.
   assign instr_stall = hold;

   // The register loads when empty or when decode takes its word.
   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         fetch.valid <= 1'b0;
         pc_q        <= '0;
      end else if (!hold) begin
         fetch.valid <= instr_valid;
         if (instr_valid) begin
            fetch.instr <= instr_data;
            fetch.pc    <= pc_q;
            pc_q        <= pc_q + 32'd4;  // Word-sized step.
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/rv32i_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_reg_file (
   input  wire                    CLK,
   input  wire                    rst_n,
   input  wire ooo_pkg::reg_idx_t rs1,
   input  wire ooo_pkg::reg_idx_t rs2,
   output ooo_pkg::data_t         rs1_data,
   output ooo_pkg::data_t         rs2_data,
   input  wire                    wen,
   input  wire ooo_pkg::reg_idx_t rd,
   input  wire ooo_pkg::data_t    wdata
);

   import ooo_pkg::*;

   data_t regs [32];

   always_ff @(posedge CLK) begin
      if (!rst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && rd != '0) begin
         regs[rd] <= wdata;  // x0 stays zero.
      end
   end

   assign rs1_data = regs[rs1];
   assign rs2_data = regs[rs2];

endmodule

`default_nettype wire

//--- tb.f
common/ooo_pkg.sv
hdl/ooo_fetch_stage.sv
decode/ooo_decode_stage.sv
execute/ooo_execute_stage.sv
commit/completion_buffer.sv
hdl/rv32i_reg_file.sv
hdl/ooo_core.sv
testbench/ooo_core_tb.sv

//--- testbench/ooo_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_core_tb;

   import ooo_pkg::*;

   localparam int cb_depth    = 4;  // Small buffer so a MUL burst fills it.
   localparam int mul_stages  = 3;
   localparam int prog_len    = 300;
   localparam int burst_len   = 16;
   localparam int n_instr     = prog_len + burst_len + 4;
   localparam int cycle_limit = 20 * n_instr + 100;

   logic        CLK;
   logic        rst_n;
   logic        instr_valid;
   data_t       instr_data;
   logic        instr_stall;
   commit_t     commit;

   data_t       exp_instr [$];
   data_t       exp_pc [$];
   data_t       ref_regs [32];
   data_t       next_pc;
   int          accepted;
   int          commits;
   int          errors;
   int          cycles;
   int unsigned seed_val;
   logic        in_burst;
   logic        stall_seen;

   ooo_core #(.CB_DEPTH(cb_depth), .MUL_STAGES(mul_stages)) ooo_core_inst (
       .CLK(CLK)
      ,.rst_n(rst_n)
      ,.instr_valid(instr_valid)
      ,.instr_data(instr_data)
      ,.instr_stall(instr_stall)
      ,.commit(commit)
   );

   always #10 CLK = ~CLK;

   // ##############################
   // Encoding and reference model
   // ##############################

   function automatic data_t enc_r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                        input reg_idx_t rs1, input logic [2:0] f3,
                                        input reg_idx_t rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic data_t enc_addi(input logic [11:0] imm, input reg_idx_t rs1,
                                      input reg_idx_t rd);
      return {imm, rs1, 3'b000, rd, 7'b0010011};
   endfunction

   function automatic logic is_supported(input data_t word);
      logic [9:0] f;
      f = {word[31:25], word[14:12]};
      if (word[6:0] == 7'b0110011) begin
         return f == 10'b0000000_000 || f == 10'b0100000_000 || f == 10'b0000000_111 ||
                f == 10'b0000000_110 || f == 10'b0000000_100 || f == 10'b0000001_000;
      end
      return word[6:0] == 7'b0010011 && word[14:12] == 3'b000;
   endfunction

   function automatic data_t expected_result(input data_t word);
      data_t a;
      data_t b;
      data_t imm;
      a   = ref_regs[word[19:15]];
      b   = ref_regs[word[24:20]];
      imm = {{20{word[31]}}, word[31:20]};
      if (!is_supported(word)) return '0;
      if (word[6:0] == 7'b0010011) return a + imm;
      case ({word[31:25], word[14:12]})
         10'b0100000_000: return a - b;
         10'b0000000_111: return a & b;
         10'b0000000_110: return a | b;
         10'b0000000_100: return a ^ b;
         10'b0000001_000: return a * b;  // Low word only.
         default:         return a + b;
      endcase
   endfunction

   function automatic data_t random_instr();
      int         kind;
      int         sel;
      reg_idx_t   rd;
      reg_idx_t   rs1;
      reg_idx_t   rs2;
      logic [2:0] f3;
      logic [6:0] f7;
      kind = $urandom_range(0, 9);
      sel  = $urandom_range(0, 4);
      rd   = reg_idx_t'($urandom_range(0, 5));  // Few registers, many hazards.
      rs1  = reg_idx_t'($urandom_range(0, 5));
      rs2  = reg_idx_t'($urandom_range(0, 5));
      f3   = (sel < 2) ? 3'b000 : (sel == 2) ? 3'b111 : (sel == 3) ? 3'b110 : 3'b100;
      f7   = (sel == 1) ? 7'b0100000 : 7'b0000000;
      if (kind < 4) return enc_r_type(f7, rs2, rs1, f3, rd);
      if (kind < 7) return enc_addi(12'($urandom), rs1, rd);
      if (kind < 9) return enc_r_type(7'b0000001, rs2, rs1, 3'b000, rd);
      if (sel < 2) return enc_r_type(7'b0000000, rs2, rs1, 3'b010, rd);  // SLT.
      if (sel < 4) return enc_r_type(7'b0000010, rs2, rs1, 3'b000, rd);
      return {25'($urandom), 7'b1100011};  // Branch opcode.
   endfunction

   // ##############################
   // Stimulus and checking
   // ##############################

   // Called at a falling edge, returns one falling edge later.
   task automatic send_instr(input data_t word);
      while (instr_stall) @(negedge CLK);
      instr_valid = 1'b1;
      instr_data  = word;
      exp_instr.push_back(word);
      exp_pc.push_back(next_pc);
      next_pc  = next_pc + 32'd4;
      accepted = accepted + 1;
      @(negedge CLK);
      instr_valid = 1'b0;
   endtask

   task automatic check_commit();
      data_t word;
      data_t pc;
      data_t exp_data;
      logic  exp_wen;
      if (exp_instr.size() == 0) begin
         $display("A commit arrived at %0t with no instruction outstanding", $time);
         errors  = errors + 1;
         commits = commits + 1;
      end else begin
         word     = exp_instr.pop_front();
         pc       = exp_pc.pop_front();
         exp_data = expected_result(word);
         exp_wen  = is_supported(word) && word[11:7] != 5'd0;
         assert (commit.pc == pc) else begin
            $display("Error at %0t: commit pc %h, expected %h", $time, commit.pc, pc);
            errors = errors + 1;
         end
         assert (commit.wen == exp_wen && (!exp_wen || commit.rd == word[11:7])) else begin
            $display("Error at %0t: pc %h wen %b rd %0d, expected wen %b rd %0d", $time, pc,
                     commit.wen, commit.rd, exp_wen, word[11:7]);
            errors = errors + 1;
         end
         assert (commit.data == exp_data) else begin
            $display("Error at %0t: pc %h data %h, expected %h", $time, pc, commit.data,
                     exp_data);
            errors = errors + 1;
         end
         if (exp_wen) ref_regs[word[11:7]] = exp_data;
         commits = commits + 1;
      end
   endtask

   always @(negedge CLK) begin
      if (rst_n) begin
         if (accepted == 0) begin
            assert (!commit.valid && !instr_stall) else begin
               $display("Error at %0t: commit or stall active before any input", $time);
               errors = errors + 1;
            end
         end
         if (commit.valid) check_commit();
         if (in_burst && instr_stall) stall_seen = 1'b1;
      end
   end

   always @(posedge CLK) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Timeout: the core did not retire all instructions in %0d cycles", cycle_limit);
         $display("Simulation FAILED");
         $finish;
      end
   end

   initial begin
      CLK         = 1'b0;
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr_data  = '0;
      next_pc     = '0;
      accepted    = 0;
      commits     = 0;
      errors      = 0;
      cycles      = 0;
      in_burst    = 1'b0;
      stall_seen  = 1'b0;
      for (int i = 0; i < 32; i++) ref_regs[i] = '0;
      seed_val = $urandom(44);
      repeat (4) @(posedge CLK);
      @(negedge CLK);
      rst_n = 1'b1;
      repeat (5) @(negedge CLK);  // Idle core stays quiet.
      for (int i = 0; i < prog_len; i++) begin
         send_instr(random_instr());
         if ($urandom_range(0, 7) == 0) @(negedge CLK);
      end
      send_instr(enc_addi(12'h123, 5'd0, 5'd1));
      send_instr(enc_addi(12'h9a5, 5'd0, 5'd2));
      wait (commits >= accepted);  // Let x1 and x2 retire first.
      @(negedge CLK);
      in_burst = 1'b1;
      for (int i = 0; i < burst_len - 2; i++) begin
         send_instr(enc_r_type(7'b0000001, 5'd2, 5'd1, 3'b000, reg_idx_t'(8 + i % 4)));
      end
      in_burst = 1'b0;
      send_instr(enc_r_type(7'b0000001, 5'd9, 5'd8, 3'b000, 5'd12));
      send_instr(enc_r_type(7'b0000000, 5'd12, 5'd12, 3'b000, 5'd13));  // Reads MUL result.
      wait (commits >= accepted);
      repeat (10) @(negedge CLK);
      assert (stall_seen) else begin
         $display("Error at %0t: instr_stall never rose during the MUL burst", $time);
         errors = errors + 1;
      end
      assert (commits == accepted && exp_instr.size() == 0) else begin
         $display("Error at %0t: %0d commits for %0d accepted", $time, commits, accepted);
         errors = errors + 1;
      end
      $display("Accepted %0d, committed %0d, errors %0d", accepted, commits, errors);
      if (errors == 0 && commits == accepted) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
